// ==== common/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data word
  localparam int unsigned XLEN = 32;
  // Register file index
  localparam int unsigned REG_ADDR_W = 5;
  // Shift amount, also sizes the multiplier step counter
  localparam int unsigned SHAMT_W = 5;

  ////////////////////
  // Operations
  ////////////////////

  // Issued operation, fixed encoding
  // Codes 5'h12 and up are undefined and decode as illegal
  typedef enum logic [4:0] {
    OP_ADD   = 5'h00,
    OP_SUB   = 5'h01,
    OP_AND   = 5'h02,
    OP_OR    = 5'h03,
    OP_XOR   = 5'h04,
    OP_SLL   = 5'h05,
    OP_SRL   = 5'h06,
    OP_SRA   = 5'h07,
    OP_SLT   = 5'h08,
    OP_SLTU  = 5'h09,
    OP_BEQ   = 5'h0a,
    OP_BNE   = 5'h0b,
    OP_BLT   = 5'h0c,
    OP_BGE   = 5'h0d,
    OP_BLTU  = 5'h0e,
    OP_BGEU  = 5'h0f,
    OP_MUL   = 5'h10,
    OP_MULHU = 5'h11
  } ex_op_e;

  // Unit that produces the result
  typedef enum logic [1:0] {
    UNIT_ALU    = 2'd0,
    UNIT_BRANCH = 2'd1,
    UNIT_MUL    = 2'd2,
    UNIT_NONE   = 2'd3
  } ex_unit_e;

  // Function applied by the ALU
  // Branch compares land on the compare group
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_fn_e;

  ////////////////////
  // Packets
  ////////////////////

  // Issued instruction, 140 bits
  typedef struct packed {
    ex_op_e                  op;
    logic [XLEN-1:0]         operand_a;
    logic [XLEN-1:0]         operand_b;
    logic [XLEN-1:0]         operand_c;   // branch target
    logic [REG_ADDR_W-1:0]   rd;
    logic                    rf_we;
    logic [XLEN-1:0]         pc;
    logic                    exc;         // fault from an earlier stage
  } id_ex_pkt_t;

  // Writeback packet, 106 bits
  typedef struct packed {
    logic                    rf_we;
    logic [REG_ADDR_W-1:0]   rd;
    logic [XLEN-1:0]         rf_wdata;
    logic [XLEN-1:0]         pc;
    logic                    illegal;
    logic                    exc;
    logic                    bch_qual;
    logic                    bch_taken;
    logic [XLEN-1:0]         bch_target;
  } ex_wb_pkt_t;

endpackage

`default_nettype wire

// ==== hw/ex_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_decode import ex_pkg::*; (
  input  ex_op_e   op_i,
  input  logic     exc_i,
  input  logic     rf_we_i,
  output ex_unit_e unit_o,
  output alu_fn_e  alu_fn_o,
  output logic     mul_high_o,
  output logic     illegal_o,
  output logic     rf_we_o
);

  ex_unit_e unit_raw;

  // Operation to unit and ALU function
  always_comb begin
    unit_raw  = UNIT_ALU;
    alu_fn_o  = ALU_ADD;
    illegal_o = 1'b0;
    case (op_i)
      OP_ADD:   alu_fn_o = ALU_ADD;
      OP_SUB:   alu_fn_o = ALU_SUB;
      OP_AND:   alu_fn_o = ALU_AND;
      OP_OR:    alu_fn_o = ALU_OR;
      OP_XOR:   alu_fn_o = ALU_XOR;
      OP_SLL:   alu_fn_o = ALU_SLL;
      OP_SRL:   alu_fn_o = ALU_SRL;
      OP_SRA:   alu_fn_o = ALU_SRA;
      OP_SLT:   alu_fn_o = ALU_SLT;
      OP_SLTU:  alu_fn_o = ALU_SLTU;
      // Branches only need the compare outcome
      OP_BEQ:   begin unit_raw = UNIT_BRANCH; alu_fn_o = ALU_EQ;  end
      OP_BNE:   begin unit_raw = UNIT_BRANCH; alu_fn_o = ALU_NE;  end
      OP_BLT:   begin unit_raw = UNIT_BRANCH; alu_fn_o = ALU_LT;  end
      OP_BGE:   begin unit_raw = UNIT_BRANCH; alu_fn_o = ALU_GE;  end
      OP_BLTU:  begin unit_raw = UNIT_BRANCH; alu_fn_o = ALU_LTU; end
      OP_BGEU:  begin unit_raw = UNIT_BRANCH; alu_fn_o = ALU_GEU; end
      OP_MUL,
      OP_MULHU: unit_raw = UNIT_MUL;
      default: begin
        // Undefined code
        unit_raw  = UNIT_NONE;
        illegal_o = 1'b1;
      end
    endcase
  end

  // Faulted instruction never reaches a unit, so no multiply starts
  assign unit_o = exc_i ? UNIT_NONE : unit_raw;

  // Picks the upper product word
  assign mul_high_o = (op_i == OP_MULHU);

  // No register write for branches, illegal codes or faults
  assign rf_we_o = rf_we_i && !illegal_o && !exc_i && (unit_raw != UNIT_BRANCH);

endmodule

`default_nettype wire

// ==== hw/ex_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_fn_e         fn_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_o
);

  logic [XLEN-1:0]    sum;
  logic [XLEN-1:0]    diff;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    sll_res;
  logic [XLEN-1:0]    srl_res;
  logic [XLEN-1:0]    sra_res;
  logic               is_eq;
  logic               lt_s;
  logic               lt_u;

  ////////////////////
  // Datapath
  ////////////////////

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Only the low bits of B count as shift amount
  assign shamt   = operand_b_i[SHAMT_W-1:0];
  assign sll_res = operand_a_i << shamt;
  assign srl_res = operand_a_i >> shamt;
  // Sign fill from bit 31
  assign sra_res = $signed(operand_a_i) >>> shamt;

  // Comparators
  assign is_eq = (operand_a_i == operand_b_i);
  assign lt_s  = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_u  = (operand_a_i < operand_b_i);

  ////////////////////
  // Compare select
  ////////////////////

  always_comb begin
    case (fn_i)
      ALU_SLT,
      ALU_LT:   cmp_o = lt_s;
      ALU_SLTU,
      ALU_LTU:  cmp_o = lt_u;
      ALU_EQ:   cmp_o = is_eq;
      ALU_NE:   cmp_o = !is_eq;
      ALU_GE:   cmp_o = !lt_s;
      ALU_GEU:  cmp_o = !lt_u;
      default:  cmp_o = 1'b0;
    endcase
  end

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    case (fn_i)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = sll_res;
      ALU_SRL:  result_o = srl_res;
      ALU_SRA:  result_o = sra_res;
      // Set-less-than writes the compare as 0/1
      ALU_SLT,
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, cmp_o};
      // Branch compares write nothing back
      default:  result_o = diff;
    endcase
  end

endmodule

`default_nettype wire

// ==== mult/ex_mult.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_mult import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic            high_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic            out_free_i,
  output logic            mul_busy_o,
  output logic            mul_done_o,
  output logic [XLEN-1:0] mul_result_o
);

  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_RUN  = 2'd1,
    MUL_HOLD = 2'd2
  } mul_state_e;

  mul_state_e          state_q;
  logic [SHAMT_W-1:0]  step_q;
  logic [XLEN-1:0]     mcand_q;
  logic [2*XLEN-1:0]   acc_q;
  logic                high_q;
  logic [XLEN:0]       partial;

  ////////////////////
  // Control FSM
  ////////////////////

  // One step per RUN cycle, last step at step_q all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        MUL_IDLE: begin
          if (start_i) begin
            state_q <= MUL_RUN;
            step_q  <= '0;
          end
        end
        MUL_RUN: begin
          step_q <= step_q + 1'b1;
          if (step_q == '1) begin
            state_q <= MUL_HOLD;
          end
        end
        MUL_HOLD: begin
          // Product leaves once the output register takes it
          if (out_free_i) begin
            state_q <= MUL_IDLE;
          end
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  ////////////////////
  // Shift-add datapath
  ////////////////////

  // Upper half plus multiplicand when the current multiplier bit is set
  assign partial = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

  always_ff @(posedge clk) begin
    if (state_q == MUL_IDLE && start_i) begin
      mcand_q <= op_a_i;
      // Multiplier sits in the low half and shifts out
      acc_q   <= {{XLEN{1'b0}}, op_b_i};
      high_q  <= high_i;
    end else if (state_q == MUL_RUN) begin
      acc_q <= {partial, acc_q[XLEN-1:1]};
    end
  end

  assign mul_busy_o   = (state_q != MUL_IDLE);
  // Strobe for the single cycle the product moves out
  assign mul_done_o   = (state_q == MUL_HOLD) && out_free_i;
  assign mul_result_o = high_q ? acc_q[2*XLEN-1:XLEN] : acc_q[XLEN-1:0];

endmodule

`default_nettype wire

// ==== hw/ex_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_result import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            instr_valid_i,
  input  id_ex_pkt_t      instr_i,
  input  ex_unit_e        unit_i,
  input  logic            illegal_i,
  input  logic            rf_we_i,
  input  logic [XLEN-1:0] alu_result_i,
  input  logic            cmp_i,
  input  logic            mul_busy_i,
  input  logic            mul_done_i,
  input  logic [XLEN-1:0] mul_result_i,
  input  logic            wb_ready_i,
  output logic            ex_ready_o,
  output logic            mul_start_o,
  output logic            out_free_o,
  output logic            ex_valid_o,
  output ex_wb_pkt_t      ex_wb_o
);

  logic                  accept;
  logic                  load_direct;
  logic                  is_branch;
  ex_wb_pkt_t            pkt_direct;
  ex_wb_pkt_t            pkt_mul;
  logic [REG_ADDR_W-1:0] mul_rd_q;
  logic [XLEN-1:0]       mul_pc_q;
  logic                  mul_we_q;

  ////////////////////
  // Handshake
  ////////////////////

  // Output slot is free when empty or being drained this cycle
  assign out_free_o  = !ex_valid_o || wb_ready_i;
  assign ex_ready_o  = !mul_busy_i && out_free_o;
  assign accept      = instr_valid_i && ex_ready_o;
  assign mul_start_o = accept && (unit_i == UNIT_MUL);
  // Everything except a multiply lands in the output register at once
  assign load_direct = accept && (unit_i != UNIT_MUL);

  // Multiply destination waits here for the product
  always_ff @(posedge clk) begin
    if (mul_start_o) begin
      mul_rd_q <= instr_i.rd;
      mul_pc_q <= instr_i.pc;
      mul_we_q <= rf_we_i;
    end
  end

  ////////////////////
  // Packet build
  ////////////////////

  assign is_branch = (unit_i == UNIT_BRANCH);

  always_comb begin
    pkt_direct.rf_we      = rf_we_i;
    pkt_direct.rd         = instr_i.rd;
    pkt_direct.rf_wdata   = alu_result_i;
    pkt_direct.pc         = instr_i.pc;
    pkt_direct.illegal    = illegal_i;
    // Illegal code is reported as an exception too
    pkt_direct.exc        = instr_i.exc || illegal_i;
    pkt_direct.bch_qual   = is_branch;
    pkt_direct.bch_taken  = is_branch && cmp_i;
    pkt_direct.bch_target = instr_i.operand_c;
  end

  always_comb begin
    pkt_mul            = '0;
    pkt_mul.rf_we      = mul_we_q;
    pkt_mul.rd         = mul_rd_q;
    pkt_mul.rf_wdata   = mul_result_i;
    pkt_mul.pc         = mul_pc_q;
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o <= 1'b0;
      ex_wb_o    <= '0;
    end else begin
      if (load_direct) begin
        ex_valid_o <= 1'b1;
        ex_wb_o    <= pkt_direct;
      end else if (mul_done_i) begin
        ex_valid_o <= 1'b1;
        ex_wb_o    <= pkt_mul;
      end else if (wb_ready_i) begin
        // Consumed with nothing behind it, bubble
        ex_valid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       instr_valid_i,
  input  id_ex_pkt_t instr_i,
  output logic       ex_ready_o,
  output logic       ex_valid_o,
  output ex_wb_pkt_t ex_wb_o,
  input  logic       wb_ready_i
);

  // Decode outputs
  ex_unit_e        unit;
  alu_fn_e         alu_fn;
  logic            mul_high;
  logic            illegal;
  logic            rf_we;

  // ALU outputs
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;

  // Multiplier handshake
  logic            mul_start;
  logic            out_free;
  logic            mul_busy;
  logic            mul_done;
  logic [XLEN-1:0] mul_result;

  ////////////////////
  // Decode
  ////////////////////

  ex_decode decode_i (
    .op_i       (instr_i.op),
    .exc_i      (instr_i.exc),
    .rf_we_i    (instr_i.rf_we),
    .unit_o     (unit),
    .alu_fn_o   (alu_fn),
    .mul_high_o (mul_high),
    .illegal_o  (illegal),
    .rf_we_o    (rf_we)
  );

  ////////////////////
  // Execute
  ////////////////////

  ex_alu alu_i (
    .fn_i        (alu_fn),
    .operand_a_i (instr_i.operand_a),
    .operand_b_i (instr_i.operand_b),
    .result_o    (alu_result),
    .cmp_o       (alu_cmp)
  );

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (mul_start),
    .high_i       (mul_high),
    .op_a_i       (instr_i.operand_a),
    .op_b_i       (instr_i.operand_b),
    .out_free_i   (out_free),
    .mul_busy_o   (mul_busy),
    .mul_done_o   (mul_done),
    .mul_result_o (mul_result)
  );

  ////////////////////
  // Result
  ////////////////////

  ex_result result_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .unit_i        (unit),
    .illegal_i     (illegal),
    .rf_we_i       (rf_we),
    .alu_result_i  (alu_result),
    .cmp_i         (alu_cmp),
    .mul_busy_i    (mul_busy),
    .mul_done_i    (mul_done),
    .mul_result_i  (mul_result),
    .wb_ready_i    (wb_ready_i),
    .ex_ready_o    (ex_ready_o),
    .mul_start_o   (mul_start),
    .out_free_o    (out_free),
    .ex_valid_o    (ex_valid_o),
    .ex_wb_o       (ex_wb_o)
  );

endmodule

`default_nettype wire

// ==== tb/ex_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 4 ns period
  localparam int HALF_NS    = 2;
  localparam int RST_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  // Reset released just after a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

  localparam int unsigned     MAX_VEC     = 64;
  localparam int unsigned     RST_CYCLES  = 8;
  localparam int unsigned     CYC_PER_VEC = 80;
  localparam logic [XLEN-1:0] PC_BASE     = 32'h0000_1000;

  logic       clk;
  logic       rst_n;
  logic       instr_valid_i;
  id_ex_pkt_t instr_i;
  logic       ex_ready_o;
  logic       ex_valid_o;
  ex_wb_pkt_t ex_wb_o;
  logic       wb_ready_i;

  // Vector table, one entry per stim line
  logic [4:0]      v_op     [0:MAX_VEC-1];
  logic [XLEN-1:0] v_a      [0:MAX_VEC-1];
  logic [XLEN-1:0] v_b      [0:MAX_VEC-1];
  logic [XLEN-1:0] v_c      [0:MAX_VEC-1];
  logic [4:0]      v_rd     [0:MAX_VEC-1];
  logic            v_we     [0:MAX_VEC-1];
  logic            v_exc    [0:MAX_VEC-1];
  logic [XLEN-1:0] e_wdata  [0:MAX_VEC-1];
  logic            e_we     [0:MAX_VEC-1];
  logic            e_exc    [0:MAX_VEC-1];
  logic            e_taken  [0:MAX_VEC-1];
  logic [XLEN-1:0] e_target [0:MAX_VEC-1];

  int          num_vec;

  ex_clk_gen clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ex_stage dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .ex_ready_o    (ex_ready_o),
    .ex_valid_o    (ex_valid_o),
    .ex_wb_o       (ex_wb_o),
    .wb_ready_i    (wb_ready_i)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic is_branch_op(input logic [4:0] op);
    return (op >= OP_BEQ) && (op <= OP_BGEU);
  endfunction

  function automatic logic is_mul_op(input logic [4:0] op);
    return (op == OP_MUL) || (op == OP_MULHU);
  endfunction

  // Everything above MULHU is undefined
  function automatic logic is_undefined_op(input logic [4:0] op);
    return op > OP_MULHU;
  endfunction

  task automatic check_val(input string name, input logic [127:0] act,
                           input logic [127:0] exp);
    if (act !== exp) begin
      $display("FAILED %s: actual 0x%0h expected 0x%0h", name, act, exp);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_with(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "run aborted");
  endtask

  task automatic load_vectors();
    int              fd;
    int              n;
    string           line;
    logic [XLEN-1:0] col [0:11];
    num_vec = 0;
    fd = $fopen("tb/ex_stim.txt", "r");
    if (fd == 0) fail_with("Could not open the stimulus file tb/ex_stim.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip comments and blank lines
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                    col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9],
                    col[10], col[11]);
        if (n == 12) begin
          if (num_vec == MAX_VEC) fail_with("Stimulus file holds too many vectors");
          v_op[num_vec]     = col[0][4:0];
          v_a[num_vec]      = col[1];
          v_b[num_vec]      = col[2];
          v_c[num_vec]      = col[3];
          v_rd[num_vec]     = col[4][4:0];
          v_we[num_vec]     = col[5][0];
          v_exc[num_vec]    = col[6][0];
          e_wdata[num_vec]  = col[7];
          e_we[num_vec]     = col[8][0];
          e_exc[num_vec]    = col[9][0];
          e_taken[num_vec]  = col[10][0];
          e_target[num_vec] = col[11];
          num_vec++;
        end else if (n > 0) begin
          fail_with("Stimulus file has a line with missing columns");
        end
      end
    end
    $fclose(fd);
    if (num_vec == 0) fail_with("Stimulus file holds no vectors");
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_vectors();
    int unsigned gap;
    @(posedge clk);
    #1;
    for (int i = 0; i < num_vec; i++) begin
      // Random idle cycles between issues
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      instr_valid_i       = 1'b1;
      instr_i.op          = ex_op_e'(v_op[i]);
      instr_i.operand_a   = v_a[i];
      instr_i.operand_b   = v_b[i];
      instr_i.operand_c   = v_c[i];
      instr_i.rd          = v_rd[i];
      instr_i.rf_we       = v_we[i];
      instr_i.pc          = PC_BASE + 4 * i;
      instr_i.exc         = v_exc[i];
      // Held until the stage takes it
      @(negedge clk);
      while (!ex_ready_o) @(negedge clk);
      @(posedge clk);
      #1;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      // Stage stays closed for the whole 32 step multiply
      if (is_mul_op(v_op[i]) && !v_exc[i]) begin
        repeat (32) begin
          @(negedge clk);
          check_val("ex_ready_o", ex_ready_o, 1'b0);
        end
        @(posedge clk);
        #1;
      end
    end
  endtask

  // Random back-pressure from writeback
  task automatic toggle_ready();
    forever begin
      @(posedge clk);
      #1;
      wb_ready_i = ($urandom % 8) >= 3;
    end
  endtask

  ////////////////////
  // Checking
  ////////////////////

  task automatic compare_output(input int k);
    logic exp_qual;
    exp_qual = is_branch_op(v_op[k]) && !v_exc[k];
    check_val("rf_we", ex_wb_o.rf_we, e_we[k]);
    check_val("rd", ex_wb_o.rd, v_rd[k]);
    // Write data only matters when something gets written
    if (e_we[k]) check_val("rf_wdata", ex_wb_o.rf_wdata, e_wdata[k]);
    check_val("pc", ex_wb_o.pc, PC_BASE + 4 * k);
    check_val("illegal", ex_wb_o.illegal, is_undefined_op(v_op[k]));
    check_val("exc", ex_wb_o.exc, e_exc[k]);
    check_val("bch_qual", ex_wb_o.bch_qual, exp_qual);
    check_val("bch_taken", ex_wb_o.bch_taken, e_taken[k]);
    check_val("bch_target", ex_wb_o.bch_target, e_target[k]);
  endtask

  // Outputs in issue order, stable while stalled
  task automatic check_outputs();
    int         k;
    logic       held;
    ex_wb_pkt_t held_pkt;
    k    = 0;
    held = 1'b0;
    while (k < num_vec) begin
      @(negedge clk);
      if (held) begin
        check_val("ex_valid_o", ex_valid_o, 1'b1);
        check_val("ex_wb_o", ex_wb_o, held_pkt);
      end
      held     = ex_valid_o && !wb_ready_i;
      held_pkt = ex_wb_o;
      if (ex_valid_o && wb_ready_i) begin
        compare_output(k);
        k++;
      end
    end
  endtask

  task automatic run_watchdog();
    repeat (num_vec * CYC_PER_VEC + RST_CYCLES) @(posedge clk);
    fail_with("Timeout, outputs stopped arriving before all vectors were checked");
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(55));
    instr_valid_i = 1'b0;
    instr_i       = '0;
    wb_ready_i    = 1'b0;
    load_vectors();
    fork
      run_watchdog();
    join_none
    @(posedge rst_n);
    // Idle state straight out of reset
    @(negedge clk);
    check_val("ex_valid_o", ex_valid_o, 1'b0);
    check_val("ex_ready_o", ex_ready_o, 1'b1);
    check_val("ex_wb_o", ex_wb_o, '0);
    fork
      toggle_ready();
      drive_vectors();
    join_none
    check_outputs();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/ex_stim.txt ====
# op a b c rd we exc | exp_wdata exp_we exp_exc exp_taken exp_target (all hex)
# exp_wdata is ignored where exp_we is 0
00 7fffffff 00000001 00000000 01 1 0 80000000 1 0 0 00000000
01 00000003 00000005 00000000 02 1 0 fffffffe 1 0 0 00000000
02 f0f0ff00 0ff0f0f0 00000000 03 1 0 00f0f000 1 0 0 00000000
03 f0000000 0000000f 00000000 04 1 0 f000000f 1 0 0 00000000
04 aaaa5555 ffff0000 00000000 05 1 0 55555555 1 0 0 00000000
05 00000001 0000001f 00000000 06 1 0 80000000 1 0 0 00000000
05 00000003 00000024 00000000 07 1 0 00000030 1 0 0 00000000
06 80000000 00000004 00000000 08 1 0 08000000 1 0 0 00000000
07 80000000 00000004 00000000 09 1 0 f8000000 1 0 0 00000000
07 fffffff0 00000002 00000000 0a 1 0 fffffffc 1 0 0 00000000
08 ffffffff 00000001 00000000 0b 1 0 00000001 1 0 0 00000000
09 ffffffff 00000001 00000000 0c 1 0 00000000 1 0 0 00000000
08 fffffffe ffffffff 00000000 0d 1 0 00000001 1 0 0 00000000
09 00000001 ffffffff 00000000 0e 1 0 00000001 1 0 0 00000000
04 00000001 00000001 00000000 0f 0 0 00000000 0 0 0 00000000
0a 12345678 12345678 00002000 00 1 0 00000000 0 0 1 00002000
0b 00000001 00000001 00002040 00 1 0 00000000 0 0 0 00002040
0c 80000000 00000001 00003000 00 1 0 00000000 0 0 1 00003000
0d 00000005 fffffffb 00003100 00 1 0 00000000 0 0 1 00003100
0e 80000000 00000001 00003200 00 1 0 00000000 0 0 0 00003200
0f 00000001 00000001 00003300 00 1 0 00000000 0 0 1 00003300
10 00010003 00020005 00000000 10 1 0 000b000f 1 0 0 00000000
11 ffffffff ffffffff 00000000 11 1 0 fffffffe 1 0 0 00000000
10 ffffffff ffffffff 00000000 12 1 0 00000001 1 0 0 00000000
11 12345678 00000010 00000000 13 1 0 00000001 1 0 0 00000000
00 00000010 00000020 00000000 14 1 0 00000030 1 0 0 00000000
12 00000001 00000002 00004000 15 1 0 00000000 0 1 0 00004000
1f 00000001 00000002 00004100 16 1 0 00000000 0 1 0 00004100
10 00000003 00000004 00005000 17 1 1 00000000 0 1 0 00005000
00 00000003 00000004 00005100 18 1 1 00000000 0 1 0 00005100
0a 00000009 00000009 00005200 19 1 1 00000000 0 1 0 00005200
11 00000002 00000003 00000000 1a 1 0 00000000 1 0 0 00000000

// ==== ex_stage.f ====
common/ex_pkg.sv
hw/ex_decode.sv
hw/ex_alu.sv
mult/ex_mult.sv
hw/ex_result.sv
hw/ex_stage.sv
tb/ex_clk_gen.sv
tb/tb_ex_stage.sv
